/* verilog.f */
+incdir+.
stepper_pkg.sv
io_register_output.sv
bus_decoder.sv
spi_master.sv
stepper_io.sv
tb_clock_gen.sv
stepper_assertions.sv
stepper_tb.sv

/* Makefile */
# Verilator build and run for the stepper io block

VERILATOR ?= verilator
TOP       ?= stepper_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

/* stepper_tb.sv */
// stepper io testbench
`timescale 1ns/1ps
`include "stepper_config.svh"

module stepper_tb
  import stepper_pkg::*;
();

  localparam logic [31:0] ADDR_LEDS      = `STEPPER_IO_BASE + 32'h00;
  localparam logic [31:0] ADDR_OUT_UPPER = `STEPPER_IO_BASE + 32'h04;
  localparam logic [31:0] ADDR_OUT_LOWER = `STEPPER_IO_BASE + 32'h08;
  localparam logic [31:0] ADDR_IN_UPPER  = `STEPPER_IO_BASE + 32'h0c;
  localparam logic [31:0] ADDR_IN_LOWER  = `STEPPER_IO_BASE + 32'h10;
  localparam logic [31:0] ADDR_CONFIG    = `STEPPER_IO_BASE + 32'h14;
  localparam logic [31:0] ADDR_STATUS    = `STEPPER_IO_BASE + 32'h18;
  localparam logic [31:0] ADDR_UNMAPPED  = `STEPPER_IO_BASE + 32'h40;
  localparam logic [31:0] ADDR_PAST_MAP  = `STEPPER_IO_BASE + 32'h1c;
  // seven transfers of about 330 cycles plus register traffic
  localparam int unsigned TIMEOUT_CYCLES = 6000;

  logic          clk_25mhz;
  logic          arst_n;
  bus_req_t      bus_req;
  bus_rsp_t      bus_rsp;
  led_t          led;
  logic          spi_sck;
  logic          spi_mosi;
  logic          spi_miso;
  logic [11:0]   spi_cs_n;
  int unsigned   cycles = 0;
  int unsigned   sck_rises = 0;

  tb_clock_gen u_clock (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n)
  );

  stepper_io u_dut (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .led       (led),
    .spi_sck   (spi_sck),
    .spi_mosi  (spi_mosi),
    .spi_miso  (spi_miso),
    .spi_cs_n  (spi_cs_n)
  );

  // loopback, every frame comes back unchanged
  assign spi_miso = spi_mosi;

  // one rising sck edge per bit shifted
  always @(posedge spi_sck) begin
    sck_rises++;
  end

  task automatic stop_on_error();
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] time %0t: %s expected 0x%0h actual 0x%0h",
               $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  // one request, held until ready, then dropped
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int waited;
    @(posedge clk_25mhz);
    #1;
    bus_req.valid = 1'b1;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    bus_req.wstrb = wstrb;
    waited = 0;
    do begin
      @(posedge clk_25mhz);
      #1;
      waited++;
    end while (!bus_rsp.ready);
    rdata = bus_rsp.rdata;
    // request stays up through the ready cycle, the write lands at its end
    @(posedge clk_25mhz);
    #1;
    bus_req = '0;
    check_eq("bus ready latency", 64'd1, 64'(waited));
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    bus_access(addr, data, 4'hf, ignored);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(addr, 32'h0, 4'h0, data);
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] expected);
    logic [31:0] value;
    bus_read(addr, value);
    check_eq(name, 64'(expected), 64'(value));
  endtask

  // load frame, pulse send, poll status, compare the returned frame
  task automatic spi_transfer(input logic [39:0] frame, input logic [3:0] cs_sel);
    logic [11:0] exp_cs;
    int unsigned exp_rises;
    logic [31:0] status;
    int          polls;
    exp_cs = (cs_sel < 4'd12) ? ~(12'b1 << cs_sel) : 12'hfff;
    exp_rises = (cs_sel < 4'd12) ? `SPI_FRAME_BITS : 0;
    bus_write(ADDR_OUT_UPPER, {24'h0, frame[39:32]});
    bus_write(ADDR_OUT_LOWER, frame[31:0]);
    bus_write(ADDR_CONFIG, {27'h0, cs_sel, 1'b0});
    sck_rises = 0;
    bus_write(ADDR_CONFIG, {27'h0, cs_sel, 1'b1});
    polls = 0;
    bus_read(ADDR_STATUS, status);
    while (status[0] == 1'b0) begin
      check_eq("spi_cs_n", 64'(exp_cs), 64'(spi_cs_n));
      polls++;
      bus_read(ADDR_STATUS, status);
    end
    assert (polls > 0) else begin
      $display("transfer never started, status was ready at the first poll");
      stop_on_error();
    end
    check_eq("spi_status", 64'd1, 64'(status));
    check_eq("spi_cs_n idle", 64'hfff, 64'(spi_cs_n));
    check_eq("spi_sck idle", 64'h0, 64'(spi_sck));
    check_eq("spi_sck rising edges", 64'(exp_rises), 64'(sck_rises));
    read_check("spi_in_upper", ADDR_IN_UPPER, {24'h0, frame[39:32]});
    read_check("spi_in_lower", ADDR_IN_LOWER, frame[31:0]);
  endtask

  task automatic test_reset_state();
    check_eq("led", 64'h0, 64'(led));
    check_eq("spi_cs_n", 64'hfff, 64'(spi_cs_n));
    check_eq("spi_sck", 64'h0, 64'(spi_sck));
    check_eq("bus_rsp.ready", 64'h0, 64'(bus_rsp.ready));
    read_check("spi_status", ADDR_STATUS, 32'h1);
    read_check("leds", ADDR_LEDS, 32'h0);
    read_check("spi_out_upper", ADDR_OUT_UPPER, 32'h0);
    read_check("spi_out_lower", ADDR_OUT_LOWER, 32'h0);
    read_check("spi_config", ADDR_CONFIG, 32'h0);
    read_check("spi_in_upper", ADDR_IN_UPPER, 32'h0);
    read_check("spi_in_lower", ADDR_IN_LOWER, 32'h0);
  endtask

  // payload widths 4, 8, 32 and 5 bits
  task automatic test_register_readback();
    bus_write(ADDR_LEDS, 32'hffff_fffa);
    read_check("leds", ADDR_LEDS, 32'h0000_000a);
    check_eq("led", 64'ha, 64'(led));
    bus_write(ADDR_OUT_UPPER, 32'h1234_56c3);
    read_check("spi_out_upper", ADDR_OUT_UPPER, 32'h0000_00c3);
    bus_write(ADDR_OUT_LOWER, 32'hdead_beef);
    read_check("spi_out_lower", ADDR_OUT_LOWER, 32'hdead_beef);
    // send bit stays clear so nothing starts
    bus_write(ADDR_CONFIG, 32'hffff_fff6);
    read_check("spi_config", ADDR_CONFIG, 32'h0000_0016);
  endtask

  task automatic test_unmapped_address();
    logic [31:0] rdata;
    bus_access(ADDR_UNMAPPED, 32'hffff_ffff, 4'hf, rdata);
    check_eq("unmapped write rdata", 64'h0, 64'(rdata));
    bus_access(ADDR_PAST_MAP, 32'h5555_5555, 4'hf, rdata);
    check_eq("unmapped write rdata", 64'h0, 64'(rdata));
    read_check("unmapped read", ADDR_UNMAPPED, 32'h0);
    read_check("leds", ADDR_LEDS, 32'h0000_000a);
    read_check("spi_out_upper", ADDR_OUT_UPPER, 32'h0000_00c3);
    read_check("spi_out_lower", ADDR_OUT_LOWER, 32'hdead_beef);
    read_check("spi_config", ADDR_CONFIG, 32'h0000_0016);
    check_eq("led", 64'ha, 64'(led));
    check_eq("spi_cs_n", 64'hfff, 64'(spi_cs_n));
  endtask

  task automatic test_loopback_transfer();
    spi_transfer(40'ha5_3c0f_e1d2, 4'd5);
  endtask

  task automatic test_random_transfers();
    logic [39:0] frame;
    logic [3:0]  cs_sel;
    for (int i = 0; i < 6; i++) begin
      frame = {8'($urandom), $urandom};
      // two of the six land on the unused selects
      if (i % 3 == 0) begin
        cs_sel = 4'(12 + $urandom_range(3, 0));
      end else begin
        cs_sel = 4'($urandom % 16);
      end
      spi_transfer(frame, cs_sel);
    end
  endtask

  always @(posedge clk_25mhz) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end
  end

  initial begin
    bus_req = '0;
    void'($urandom(88101));
    wait (arst_n === 1'b1);
    test_reset_state();
    test_register_readback();
    test_unmapped_address();
    test_loopback_transfer();
    test_random_transfers();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* stepper_assertions.sv */
// bus and spi pin assertions
`timescale 1ns/1ps

module stepper_assertions #(
  parameter bit CHECK_SPI = 1'b1,
  parameter bit CHECK_BUS = 1'b1
) (
  input logic        clk_25mhz,
  input logic        arst_n,
  input logic [11:0] cs_n,
  input logic        sck,
  input logic        bus_ready
);

  // one driver chip at a time
  cs_onehot: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
    !CHECK_SPI || ($countones(~cs_n) <= 1))
    else $error("more than one cs_n line low");

  // ready is a single cycle pulse
  ready_pulse: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
    (CHECK_BUS && bus_ready) |=> !bus_ready)
    else $error("bus ready high in two consecutive cycles");

  // no clock on the wire without a selected chip
  sck_idle: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
    (CHECK_SPI && (&cs_n)) |-> !sck)
    else $error("sck high while no cs_n line is low");

endmodule

bind spi_master stepper_assertions #(.CHECK_SPI(1'b1), .CHECK_BUS(1'b0)) u_spi_checks (
  .clk_25mhz (clk_25mhz),
  .arst_n    (arst_n),
  .cs_n      (cs_n),
  .sck       (sck),
  .bus_ready (1'b0)
);

bind bus_decoder stepper_assertions #(.CHECK_SPI(1'b0), .CHECK_BUS(1'b1)) u_bus_checks (
  .clk_25mhz (clk_25mhz),
  .arst_n    (arst_n),
  .cs_n      (12'hfff),
  .sck       (1'b0),
  .bus_ready (rsp.ready)
);

/* tb_clock_gen.sv */
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_25mhz,
  output logic arst_n
);

  initial begin
    clk_25mhz = 1'b0;
    forever #(PERIOD_NS / 2) clk_25mhz = ~clk_25mhz;
  end

  // release just after an edge, like the other inputs
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_25mhz);
    #1;
    arst_n = 1'b1;
  end

endmodule

/* stepper_io.sv */
// stepper driver i/o block
`timescale 1ns/1ps

module stepper_io
  import stepper_pkg::*;
(
  input  logic        clk_25mhz,
  input  logic        arst_n,
  input  bus_req_t    bus_req,
  output bus_rsp_t    bus_rsp,
  output led_t        led,
  output logic        spi_sck,
  output logic        spi_mosi,
  input  logic        spi_miso,
  output logic [11:0] spi_cs_n
);

  logic [6:0]       sel;
  logic             write;
  logic [3:0][31:0] slot_rdata;
  logic [39:0]      rx_frame;
  logic             spi_ready;
  spi_frame_hi_t    frame_hi;
  logic [31:0]      frame_lo;
  spi_cfg_t         spi_cfg;

  bus_decoder u_decoder (
    .clk_25mhz  (clk_25mhz),
    .arst_n     (arst_n),
    .req        (bus_req),
    .rsp        (bus_rsp),
    .sel        (sel),
    .write      (write),
    .slot_rdata (slot_rdata),
    .rx_frame   (rx_frame),
    .spi_ready  (spi_ready)
  );

  // offset 0x00
  io_register_output #(.payload_t(led_t)) u_leds (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .sel       (sel[0]),
    .write     (write),
    .wdata     (bus_req.wdata),
    .rdata     (slot_rdata[0]),
    .q         (led)
  );

  // offset 0x04, top byte of the frame
  io_register_output #(.payload_t(spi_frame_hi_t)) u_spi_out_upper (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .sel       (sel[1]),
    .write     (write),
    .wdata     (bus_req.wdata),
    .rdata     (slot_rdata[1]),
    .q         (frame_hi)
  );

  // offset 0x08
  io_register_output #(.payload_t(logic [31:0])) u_spi_out_lower (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .sel       (sel[2]),
    .write     (write),
    .wdata     (bus_req.wdata),
    .rdata     (slot_rdata[2]),
    .q         (frame_lo)
  );

  // offset 0x14, receive halves and status are read in the decoder
  io_register_output #(.payload_t(spi_cfg_t)) u_spi_config (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .sel       (sel[5]),
    .write     (write),
    .wdata     (bus_req.wdata),
    .rdata     (slot_rdata[3]),
    .q         (spi_cfg)
  );

  spi_master u_spi (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .cfg       (spi_cfg),
    .tx_frame  ({frame_hi, frame_lo}),
    .rx_frame  (rx_frame),
    .ready     (spi_ready),
    .sck       (spi_sck),
    .mosi      (spi_mosi),
    .miso      (spi_miso),
    .cs_n      (spi_cs_n)
  );

endmodule

/* spi_master.sv */
// spi master for the driver chips
`timescale 1ns/1ps
`include "stepper_config.svh"

module spi_master
  import stepper_pkg::*;
(
  input  logic        clk_25mhz,
  input  logic        arst_n,
  input  spi_cfg_t    cfg,
  input  logic [39:0] tx_frame,
  output logic [39:0] rx_frame,
  output logic        ready,
  output logic        sck,
  output logic        mosi,
  input  logic        miso,
  output logic [11:0] cs_n
);

  localparam int FRAME = `SPI_FRAME_BITS;
  localparam int CS_COUNT = `SPI_CS_COUNT;
  localparam int HALF = `SPI_HALF_PERIOD;
  localparam int DIV_W = (HALF > 1) ? $clog2(HALF) : 1;
  localparam int BIT_W = $clog2(FRAME);

  logic                busy;
  logic                setup;
  logic                send_d;
  logic [DIV_W-1:0]    div_cnt;
  logic [BIT_W-1:0]    bit_cnt;
  logic                sck_q;
  logic [FRAME-1:0]    tx_sr;
  logic [FRAME-1:0]    rx_sr;
  logic [CS_COUNT-1:0] cs_dec;
  logic                start;
  logic                tick;
  logic                rise_tick;
  logic                fall_tick;
  logic                last;

  // send edge while idle, edges during a transfer are dropped
  assign start = cfg.send && !send_d && !busy;

  // half period elapsed, setup cycle excluded
  assign tick      = busy && !setup && (div_cnt == DIV_W'(HALF - 1));
  assign rise_tick = tick && !sck_q;
  assign fall_tick = tick && sck_q;
  assign last      = fall_tick && (bit_cnt == BIT_W'(FRAME - 1));

  // one hot active low select, indices past the last chip select nothing
  always_comb begin
    for (int i = 0; i < CS_COUNT; i++) begin
      cs_dec[i] = (cfg.cs_sel != 4'(i));
    end
  end

  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      setup    <= 1'b0;
      send_d   <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      sck_q    <= 1'b0;
      cs_n     <= '1;
      rx_frame <= '0;
    end else begin
      send_d <= cfg.send;
      if (start) begin
        busy    <= 1'b1;
        setup   <= 1'b1;
        div_cnt <= '0;
        bit_cnt <= '0;
        sck_q   <= 1'b0;
        cs_n    <= cs_dec;
      end else if (busy) begin
        if (setup) begin
          // msb already on mosi, give it one cycle
          setup <= 1'b0;
        end else if (tick) begin
          div_cnt <= '0;
          sck_q   <= !sck_q;
          if (fall_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          if (last) begin
            busy     <= 1'b0;
            cs_n     <= '1;
            rx_frame <= rx_sr;
          end
        end else begin
          div_cnt <= div_cnt + 1'b1;
        end
      end
    end
  end

  // mode 0 shifting, out on falling and in on rising sck
  always_ff @(posedge clk_25mhz) begin
    if (start) begin
      tx_sr <= tx_frame;
    end else if (fall_tick) begin
      tx_sr <= tx_sr << 1;
    end
    if (rise_tick) begin
      rx_sr <= {rx_sr[FRAME-2:0], miso};
    end
  end

  assign mosi  = tx_sr[FRAME-1];
  assign ready = !busy;

  // no clock on the wire when no driver is selected
  assign sck = sck_q && !(&cs_n);

endmodule

/* bus_decoder.sv */
// bus address decoder
`timescale 1ns/1ps
`include "stepper_config.svh"

module bus_decoder
  import stepper_pkg::*;
(
  input  logic             clk_25mhz,
  input  logic             arst_n,
  input  bus_req_t         req,
  output bus_rsp_t         rsp,
  output logic [6:0]       sel,
  output logic             write,
  input  logic [3:0][31:0] slot_rdata,
  input  logic [39:0]      rx_frame,
  input  logic             spi_ready
);

  localparam int NUM_SEL = 7;
  localparam logic [29:0] BASE_WORD = 30'(`STEPPER_IO_BASE >> 2);

  logic [NUM_SEL-1:0] hit;
  logic               accept;
  logic               ready_q;
  logic [31:0]        rdata_mux;

  // sel[i] belongs to the word at base + 4*i
  always_comb begin
    for (int i = 0; i < NUM_SEL; i++) begin
      hit[i] = (req.addr[31:2] == BASE_WORD + 30'(i));
    end
  end

  // a request is taken once, not again while ready is up
  assign accept = req.valid && !ready_q;

  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      sel     <= '0;
      write   <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
      if (accept) begin
        sel   <= hit;
        write <= |req.wstrb;
      end else begin
        sel   <= '0;
        write <= 1'b0;
      end
    end
  end

  // read mux, nothing selected gives zero
  always_comb begin
    case (1'b1)
      sel[0]:  rdata_mux = slot_rdata[0];
      sel[1]:  rdata_mux = slot_rdata[1];
      sel[2]:  rdata_mux = slot_rdata[2];
      sel[3]:  rdata_mux = 32'(rx_frame[`SPI_FRAME_BITS-1:32]);
      sel[4]:  rdata_mux = rx_frame[31:0];
      sel[5]:  rdata_mux = slot_rdata[3];
      sel[6]:  rdata_mux = 32'(spi_ready);
      default: rdata_mux = '0;
    endcase
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_mux;

endmodule

/* io_register_output.sv */
// bus writable register slot
`timescale 1ns/1ps

module io_register_output #(
  parameter type payload_t = logic [31:0]
) (
  input  logic        clk_25mhz,
  input  logic        arst_n,
  input  logic        sel,
  input  logic        write,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output payload_t    q
);

  localparam int W = $bits(payload_t);

  logic [W-1:0] q_bits;

  // only the low payload bits of the bus word are kept
  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (sel && write) begin
      q <= payload_t'(wdata[W-1:0]);
    end
  end

  // flat view of the payload for read-back
  assign q_bits = q;

  // zero extended to the bus width
  assign rdata = 32'(q_bits);

endmodule

/* stepper_pkg.sv */
// stepper io bus and register types
package stepper_pkg;

  // host request, nonzero strobe means write
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } bus_rsp_t;

  typedef logic [3:0] led_t;

  // send in bit 0, chip select index above it
  typedef struct packed {
    logic [3:0] cs_sel;
    logic       send;
  } spi_cfg_t;

  typedef logic [7:0] spi_frame_hi_t;

endpackage

/* stepper_config.svh */
// stepper io parameters
`ifndef STEPPER_CONFIG_SVH
`define STEPPER_CONFIG_SVH

// i/o window, registers sit on word offsets 0x00 to 0x18
`define STEPPER_IO_BASE 32'h1000_0000

// spi frame and driver chip count
`define SPI_FRAME_BITS 40
`define SPI_CS_COUNT 12

// system clocks per sck half period
`define SPI_HALF_PERIOD 4

`endif
